// File: filelist.f
source/hash_map_pkg.sv
source/node_ram_if.sv
source/hash_crc.sv
source/node_ram.sv
source/hash_map_ctrl.sv
source/hash_map.sv
verification/hash_map_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the hash map simulation with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module hash_map_tb \
  -f filelist.f -o hash_map_sim
./obj_dir/hash_map_sim | tee sim.log

if grep -q "Testbench failed" sim.log; then
  exit 1
fi

// File: verification/hash_map_tb.sv
// Hash map testbench
// Directed tests of lookup, add, chaining, full flag and clear,
// checked against a reference model of the CRC bucket hash and of the map
`timescale 1ns/1ns
`default_nettype none

module hash_map_tb;

  localparam int KEY_BITS = 32;
  localparam int DAT_BITS = 8;
  localparam int BKT_AW   = 3;
  localparam int CHN_AW   = 3;
  localparam int NODES    = 2**CHN_AW - 1;
  localparam int TMO      = 200;
  // Generator polynomial with its x^32 term
  localparam logic [63:0] GEN = 64'h0000_0001_04C1_1DB7;

  logic                i_clk;
  logic                coll_ram_rst;
  logic [KEY_BITS-1:0] i_key;
  logic [DAT_BITS-1:0] i_dat;
  logic                i_opcode;
  logic                i_val;
  logic                i_cfg_clr;
  logic                o_rdy;
  logic                o_val;
  logic                o_fnd;
  logic [DAT_BITS-1:0] o_dat;
  logic                o_cfg_full;

  // Reference model of the map
  logic [DAT_BITS-1:0] ref_map [logic [KEY_BITS-1:0]];
  int                  bkt_cnt [2**BKT_AW];
  int                  chn_used;
  logic [KEY_BITS-1:0] added [$];
  logic [KEY_BITS-1:0] coll_keys [$];
  logic [BKT_AW-1:0]   coll_bkt;

  logic [31:0] rng;
  string       tname;
  int          errs;
  int          total_errs;
  int          tests;

  hash_map #(
    .KEY_BITS (KEY_BITS),
    .DAT_BITS (DAT_BITS),
    .BKT_AW   (BKT_AW),
    .CHN_AW   (CHN_AW)
  ) u_dut (
    .i_clk        (i_clk),
    .coll_ram_rst (coll_ram_rst),
    .i_key        (i_key),
    .i_dat        (i_dat),
    .i_opcode     (i_opcode),
    .i_val        (i_val),
    .i_cfg_clr    (i_cfg_clr),
    .o_rdy        (o_rdy),
    .o_val        (o_val),
    .o_fnd        (o_fnd),
    .o_dat        (o_dat),
    .o_cfg_full   (o_cfg_full)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  function automatic logic [31:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Remainder of key * x^32 by long division, low bits pick the bucket
  function automatic logic [BKT_AW-1:0] ref_hash(input logic [KEY_BITS-1:0] key);
    logic [63:0] r;
    r = 64'(key) << 32;
    for (int b = 63; b >= 32; b--) begin
      if (r[b]) begin
        r = r ^ (GEN << (b - 32));
      end
    end
    return r[BKT_AW-1:0];
  endfunction

  // Returns the expected o_fnd of an add
  function automatic logic ref_add(input logic [KEY_BITS-1:0] key,
                                   input logic [DAT_BITS-1:0] dat);
    logic [BKT_AW-1:0] h;
    h = ref_hash(key);
    if (ref_map.exists(key)) begin
      ref_map[key] = dat;
      return 1'b1;
    end
    if (bkt_cnt[h] != 0) begin
      // New key needs a chain node, dropped when none is left
      if (chn_used == NODES) begin
        return 1'b0;
      end
      chn_used++;
    end
    bkt_cnt[h]++;
    ref_map[key] = dat;
    added.push_back(key);
    return 1'b0;
  endfunction

  function automatic void ref_clear();
    ref_map.delete();
    foreach (bkt_cnt[b]) begin
      bkt_cnt[b] = 0;
    end
    chn_used = 0;
  endfunction

  // Random key that hashes to idx and is not in the model yet
  function automatic logic [KEY_BITS-1:0] key_in_bucket(input logic [BKT_AW-1:0] idx);
    logic [KEY_BITS-1:0] k;
    k = KEY_BITS'(xorshift());
    for (int i = 0; i < 4096 && (ref_hash(k) != idx || ref_map.exists(k)); i++) begin
      k = KEY_BITS'(xorshift());
    end
    return k;
  endfunction

  task automatic abort_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Testbench failed");
    $finish;
  endtask

  task automatic wait_ready(input string what);
    int n;
    n = 0;
    do begin
      @(posedge i_clk);
      n++;
    end while (o_rdy !== 1'b1 && n < TMO);
    if (o_rdy !== 1'b1) begin
      abort_timeout(what);
    end
  endtask

  // One request through valid/ready, result taken during the o_val pulse
  task automatic run_op(input logic op, input logic [KEY_BITS-1:0] key,
                        input logic [DAT_BITS-1:0] dat, output logic fnd,
                        output logic [DAT_BITS-1:0] rdat);
    int n;
    @(posedge i_clk);
    i_key    <= key;
    i_dat    <= dat;
    i_opcode <= op;
    i_val    <= 1'b1;
    wait_ready("request acceptance");
    i_val <= 1'b0;
    n = 0;
    do begin
      @(posedge i_clk);
      n++;
    end while (o_val !== 1'b1 && n < TMO);
    if (o_val !== 1'b1) begin
      abort_timeout("the result pulse");
    end else begin
      fnd  = o_fnd;
      rdat = o_dat;
      // Ready returns together with the result pulse
      if (o_rdy !== 1'b1) begin
        $display("Mismatch in %s: o_rdy during o_val expected 1, actual %b", tname, o_rdy);
        errs++;
      end
    end
  endtask

  task automatic lookup_check(input logic [KEY_BITS-1:0] key);
    logic                fnd;
    logic                exp_fnd;
    logic [DAT_BITS-1:0] rdat;
    exp_fnd = ref_map.exists(key);
    run_op(1'b0, key, '0, fnd, rdat);
    if (fnd !== exp_fnd) begin
      $display("Mismatch in %s: key %h o_fnd expected %b, actual %b",
               tname, key, exp_fnd, fnd);
      errs++;
    end else if (exp_fnd && rdat !== ref_map[key]) begin
      $display("Mismatch in %s: key %h o_dat expected %h, actual %h",
               tname, key, ref_map[key], rdat);
      errs++;
    end
  endtask

  task automatic add_check(input logic [KEY_BITS-1:0] key, input logic [DAT_BITS-1:0] dat);
    logic                fnd;
    logic                exp_fnd;
    logic                exp_full;
    logic [DAT_BITS-1:0] rdat;
    exp_fnd  = ref_add(key, dat);
    exp_full = (chn_used == NODES);
    run_op(1'b1, key, dat, fnd, rdat);
    if (fnd !== exp_fnd) begin
      $display("Mismatch in %s: add of key %h o_fnd expected %b, actual %b",
               tname, key, exp_fnd, fnd);
      errs++;
    end
    // Full flag changes on the same edge as the result pulse
    if (o_cfg_full !== exp_full) begin
      $display("Mismatch in %s: o_cfg_full expected %b, actual %b",
               tname, exp_full, o_cfg_full);
      errs++;
    end
  endtask

  task automatic report_test();
    $display("Test %s finished with %0d errors", tname, errs);
    total_errs += errs;
    tests++;
  endtask

  task automatic test_reset();
    tname = "reset";
    errs  = 0;
    repeat (4) @(posedge i_clk);
    if (o_rdy !== 1'b0 || o_val !== 1'b0 || o_fnd !== 1'b0 || o_cfg_full !== 1'b0) begin
      $display("Mismatch in %s: rdy val fnd full expected 0000, actual %b%b%b%b",
               tname, o_rdy, o_val, o_fnd, o_cfg_full);
      errs++;
    end
    coll_ram_rst <= 1'b1;
    wait_ready("o_rdy after reset");
    if (o_cfg_full !== 1'b0) begin
      $display("Mismatch in %s: o_cfg_full expected 0, actual %b", tname, o_cfg_full);
      errs++;
    end
    for (int i = 0; i < 4; i++) begin
      lookup_check(KEY_BITS'(xorshift()));
    end
    report_test();
  endtask

  task automatic test_distinct();
    logic [KEY_BITS-1:0] keys [$];
    logic [KEY_BITS-1:0] k;
    tname = "distinct";
    errs  = 0;
    for (int b = 0; b < 2**BKT_AW && keys.size() < 4; b++) begin
      if (bkt_cnt[b] == 0) begin
        k = key_in_bucket(BKT_AW'(b));
        keys.push_back(k);
        add_check(k, DAT_BITS'(xorshift()));
      end
    end
    foreach (keys[i]) begin
      lookup_check(keys[i]);
    end
    report_test();
  endtask

  // Four keys in one bucket, the fifth one stays out
  task automatic test_collide();
    tname    = "collide";
    errs     = 0;
    coll_bkt = '0;
    foreach (bkt_cnt[b]) begin
      if (bkt_cnt[b] == 0) begin
        coll_bkt = BKT_AW'(b);
      end
    end
    for (int i = 0; i < 5; i++) begin
      coll_keys.push_back(key_in_bucket(coll_bkt));
    end
    for (int i = 0; i < 4; i++) begin
      add_check(coll_keys[i], DAT_BITS'(xorshift()));
    end
    foreach (coll_keys[i]) begin
      lookup_check(coll_keys[i]);
    end
    report_test();
  endtask

  // Bucket head and chain tail get new data
  task automatic test_overwrite();
    tname = "overwrite";
    errs  = 0;
    add_check(added[0], ~ref_map[added[0]]);
    add_check(coll_keys[3], ~ref_map[coll_keys[3]]);
    lookup_check(added[0]);
    lookup_check(coll_keys[3]);
    report_test();
  endtask

  task automatic test_full();
    logic [KEY_BITS-1:0] k;
    tname = "full";
    errs  = 0;
    for (int i = 0; i < 2 * NODES && chn_used < NODES; i++) begin
      add_check(key_in_bucket(coll_bkt), DAT_BITS'(xorshift()));
    end
    if (o_cfg_full !== 1'b1) begin
      $display("Mismatch in %s: o_cfg_full expected 1, actual %b", tname, o_cfg_full);
      errs++;
    end
    k = key_in_bucket(coll_bkt);
    add_check(k, DAT_BITS'(xorshift()));
    lookup_check(k);
    report_test();
  endtask

  task automatic test_clear();
    tname = "clear";
    errs  = 0;
    @(posedge i_clk);
    i_cfg_clr <= 1'b1;
    @(posedge i_clk);
    i_cfg_clr <= 1'b0;
    @(posedge i_clk);
    if (o_rdy !== 1'b0) begin
      $display("Mismatch in %s: o_rdy after the clear pulse expected 0, actual %b",
               tname, o_rdy);
      errs++;
    end
    wait_ready("o_rdy after clear");
    if (o_cfg_full !== 1'b0) begin
      $display("Mismatch in %s: o_cfg_full expected 0, actual %b", tname, o_cfg_full);
      errs++;
    end
    ref_clear();
    foreach (added[i]) begin
      lookup_check(added[i]);
    end
    report_test();
  endtask

  initial begin
    rng          = 32'h58285590;
    total_errs   = 0;
    tests        = 0;
    coll_ram_rst = 1'b0;
    i_key        = '0;
    i_dat        = '0;
    i_opcode     = 1'b0;
    i_val        = 1'b0;
    i_cfg_clr    = 1'b0;
    ref_clear();
    test_reset();
    test_distinct();
    test_collide();
    test_overwrite();
    test_full();
    test_clear();
    $display("%0d tests run, %0d errors", tests, total_errs);
    if (total_errs == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/hash_map.sv
// Hash map top level
// CRC-32 hashed bucket memory with collisions chained through a node memory
`timescale 1ns/1ns
`default_nettype none

module hash_map #(
  parameter int KEY_BITS = 32,
  parameter int DAT_BITS = 8,
  parameter int BKT_AW   = 3,
  parameter int CHN_AW   = 3
) (
  input  wire logic                i_clk,
  input  wire logic                coll_ram_rst,
  input  wire logic [KEY_BITS-1:0] i_key,
  input  wire logic [DAT_BITS-1:0] i_dat,
  input  wire logic                i_opcode,
  input  wire logic                i_val,
  input  wire logic                i_cfg_clr,
  output logic                     o_rdy,
  output logic                     o_val,
  output logic                     o_fnd,
  output logic      [DAT_BITS-1:0] o_dat,
  output logic                     o_cfg_full
);

  // used + key + data + next pointer
  localparam int NODE_W = 1 + KEY_BITS + DAT_BITS + CHN_AW;

  logic [KEY_BITS-1:0] hash_key;
  logic [BKT_AW-1:0]   bkt_idx;

  node_ram_if #(.WIDTH(NODE_W), .AW(BKT_AW)) bkt_if ();
  node_ram_if #(.WIDTH(NODE_W), .AW(CHN_AW)) chn_if ();

  hash_map_ctrl #(
    .KEY_BITS (KEY_BITS),
    .DAT_BITS (DAT_BITS),
    .BKT_AW   (BKT_AW),
    .CHN_AW   (CHN_AW)
  ) u_ctrl (
    .i_clk        (i_clk),
    .coll_ram_rst (coll_ram_rst),
    .i_key        (i_key),
    .i_dat        (i_dat),
    .i_opcode     (i_opcode),
    .i_val        (i_val),
    .o_rdy        (o_rdy),
    .o_val        (o_val),
    .o_fnd        (o_fnd),
    .o_dat        (o_dat),
    .i_cfg_clr    (i_cfg_clr),
    .o_cfg_full   (o_cfg_full),
    .o_hash_key   (hash_key),
    .i_bkt_idx    (bkt_idx),
    .bkt          (bkt_if.ctrl),
    .chn          (chn_if.ctrl)
  );

  hash_crc #(
    .KEY_BITS (KEY_BITS),
    .BKT_AW   (BKT_AW)
  ) u_crc (
    .i_key (hash_key),
    .o_idx (bkt_idx)
  );

  // First level, one node per bucket
  node_ram #(.WIDTH(NODE_W), .AW(BKT_AW)) u_bkt_ram (
    .i_clk (i_clk),
    .mem   (bkt_if.mem)
  );

  // Collision chain nodes
  node_ram #(.WIDTH(NODE_W), .AW(CHN_AW)) u_chn_ram (
    .i_clk (i_clk),
    .mem   (chn_if.mem)
  );

endmodule

`default_nettype wire

// File: source/hash_map_ctrl.sv
// Hash map control FSM
// Clears the bucket memory, runs lookups and adds, walks the collision
// chain and hands out chain nodes from a simple allocator
`timescale 1ns/1ns
`default_nettype none

module hash_map_ctrl #(
  parameter int KEY_BITS = 32,
  parameter int DAT_BITS = 8,
  parameter int BKT_AW   = 3,
  parameter int CHN_AW   = 3
) (
  input  wire logic                i_clk,
  input  wire logic                coll_ram_rst,
  input  wire logic [KEY_BITS-1:0] i_key,
  input  wire logic [DAT_BITS-1:0] i_dat,
  input  wire logic                i_opcode,
  input  wire logic                i_val,
  output logic                     o_rdy,
  output logic                     o_val,
  output logic                     o_fnd,
  output logic      [DAT_BITS-1:0] o_dat,
  input  wire logic                i_cfg_clr,
  output logic                     o_cfg_full,
  output logic      [KEY_BITS-1:0] o_hash_key,
  input  wire logic [BKT_AW-1:0]   i_bkt_idx,
  node_ram_if.ctrl                 bkt,
  node_ram_if.ctrl                 chn
);

  // Stored node, nxt == 0 ends the list
  typedef struct packed {
    logic                used;
    logic [KEY_BITS-1:0] key;
    logic [DAT_BITS-1:0] dat;
    logic [CHN_AW-1:0]   nxt;
  } node_t;

  hash_map_pkg::state_t  state;
  hash_map_pkg::opcode_t req_op;

  logic [KEY_BITS-1:0] req_key;
  logic [DAT_BITS-1:0] req_dat;
  logic [BKT_AW-1:0]   clr_cnt;
  logic [CHN_AW-1:0]   alloc;
  logic [CHN_AW-1:0]   chn_addr;

  node_t bkt_rd;
  node_t chn_rd;
  node_t new_node;
  node_t bkt_wd;
  node_t chn_wd;

  logic                is_add;
  logic                bkt_we;
  logic                chn_we;
  logic                done;
  logic                hit;
  logic                take;
  logic [CHN_AW-1:0]   walk_ptr;
  logic [DAT_BITS-1:0] hit_dat;

  assign bkt_rd = bkt.rdata;
  assign chn_rd = chn.rdata;
  assign is_add = (req_op == hash_map_pkg::OP_ADD);

  // Hash the incoming key while idle, the held key afterwards
  assign o_hash_key = (state == hash_map_pkg::ST_IDLE) ? i_key : req_key;

  always_comb begin
    new_node.used = 1'b1;
    new_node.key  = req_key;
    new_node.dat  = req_dat;
    new_node.nxt  = '0;
  end

  // Decision logic for the evaluate states
  always_comb begin
    bkt_we   = 1'b0;
    bkt_wd   = '0;
    chn_we   = 1'b0;
    chn_wd   = new_node;
    done     = 1'b0;
    hit      = 1'b0;
    take     = 1'b0;
    walk_ptr = bkt_rd.nxt;
    hit_dat  = bkt_rd.dat;
    case (state)
      hash_map_pkg::ST_CLEAR: begin
        bkt_we = 1'b1;
      end
      hash_map_pkg::ST_BKT_EVAL: begin
        if (!bkt_rd.used) begin
          done = 1'b1;
          if (is_add) begin
            bkt_we = 1'b1;
            bkt_wd = new_node;
          end
        end else if (bkt_rd.key == req_key) begin
          done = 1'b1;
          hit  = 1'b1;
          if (is_add) begin
            bkt_we     = 1'b1;
            bkt_wd     = bkt_rd;
            bkt_wd.dat = req_dat;
          end
        end else begin
          // Prepare the new node early, it stays unlinked if the key shows up later
          if (is_add && !o_cfg_full) begin
            chn_we = 1'b1;
          end
          if (bkt_rd.nxt == '0) begin
            done = 1'b1;
            if (is_add && !o_cfg_full) begin
              bkt_we     = 1'b1;
              bkt_wd     = bkt_rd;
              bkt_wd.nxt = alloc;
              take       = 1'b1;
            end
          end
        end
      end
      hash_map_pkg::ST_CHN_EVAL: begin
        walk_ptr = chn_rd.nxt;
        hit_dat  = chn_rd.dat;
        if (chn_rd.key == req_key) begin
          done = 1'b1;
          hit  = 1'b1;
          if (is_add) begin
            chn_we     = 1'b1;
            chn_wd     = chn_rd;
            chn_wd.dat = req_dat;
          end
        end else if (chn_rd.nxt == '0) begin
          done = 1'b1;
          // Tail node now points at the node written during the bucket stage
          if (is_add && !o_cfg_full) begin
            chn_we     = 1'b1;
            chn_wd     = chn_rd;
            chn_wd.nxt = alloc;
            take       = 1'b1;
          end
        end
      end
      default: begin
        done = 1'b0;
      end
    endcase
  end

  assign bkt.addr  = (state == hash_map_pkg::ST_CLEAR) ? clr_cnt : i_bkt_idx;
  assign bkt.we    = bkt_we;
  assign bkt.wdata = bkt_wd;
  // Bucket stage writes the spare node at the allocator slot
  assign chn.addr  = (state == hash_map_pkg::ST_BKT_EVAL) ? alloc : chn_addr;
  assign chn.we    = chn_we;
  assign chn.wdata = chn_wd;

  always_ff @(posedge i_clk) begin
    if (!coll_ram_rst) begin
      state      <= hash_map_pkg::ST_CLEAR;
      clr_cnt    <= '0;
      alloc      <= CHN_AW'(1);
      o_cfg_full <= 1'b0;
      o_rdy      <= 1'b0;
      o_val      <= 1'b0;
      o_fnd      <= 1'b0;
    end else begin
      o_val <= 1'b0;
      o_fnd <= 1'b0;
      case (state)
        hash_map_pkg::ST_CLEAR: begin
          clr_cnt <= clr_cnt + 1'b1;
          if (clr_cnt == '1) begin
            state <= hash_map_pkg::ST_IDLE;
            o_rdy <= 1'b1;
          end
        end
        hash_map_pkg::ST_IDLE: begin
          if (i_val && o_rdy) begin
            o_rdy <= 1'b0;
            state <= hash_map_pkg::ST_BKT_WAIT;
          end
        end
        hash_map_pkg::ST_BKT_WAIT: begin
          state <= hash_map_pkg::ST_BKT_EVAL;
        end
        hash_map_pkg::ST_CHN_WAIT: begin
          state <= hash_map_pkg::ST_CHN_EVAL;
        end
        hash_map_pkg::ST_BKT_EVAL, hash_map_pkg::ST_CHN_EVAL: begin
          if (done) begin
            state <= hash_map_pkg::ST_IDLE;
            o_rdy <= 1'b1;
            o_val <= 1'b1;
            o_fnd <= hit;
          end else begin
            state <= hash_map_pkg::ST_CHN_WAIT;
          end
        end
        default: begin
          state <= hash_map_pkg::ST_CLEAR;
        end
      endcase
      if (take) begin
        alloc <= alloc + 1'b1;
        // Last node handed out
        if (alloc == '1) begin
          o_cfg_full <= 1'b1;
        end
      end
      // Clear wins over any operation in flight
      if (i_cfg_clr) begin
        state      <= hash_map_pkg::ST_CLEAR;
        clr_cnt    <= '0;
        alloc      <= CHN_AW'(1);
        o_cfg_full <= 1'b0;
        o_rdy      <= 1'b0;
        o_val      <= 1'b0;
      end
    end
  end

  // Request and walk registers
  always_ff @(posedge i_clk) begin
    if (state == hash_map_pkg::ST_IDLE) begin
      req_key <= i_key;
      req_dat <= i_dat;
      req_op  <= hash_map_pkg::opcode_t'(i_opcode);
    end
    if (done) begin
      o_dat <= hit_dat;
    end else if (state == hash_map_pkg::ST_BKT_EVAL ||
                 state == hash_map_pkg::ST_CHN_EVAL) begin
      // Node to visit next, held through its wait and evaluate cycles
      chn_addr <= walk_ptr;
    end
  end

  a_no_val_in_clear: assert property (
    @(posedge i_clk) disable iff (!coll_ram_rst)
    (state == hash_map_pkg::ST_CLEAR) |-> !o_val
  );

  // Chain address 0 terminates lists and is never stored to
  a_no_chn_wr_zero: assert property (
    @(posedge i_clk) disable iff (!coll_ram_rst)
    chn.we |-> (chn.addr != '0)
  );

endmodule

`default_nettype wire

// File: source/node_ram.sv
// Node memory
// Single-port RAM of 2^AW words with a one-cycle registered read;
// a read during a write returns the old word
`timescale 1ns/1ns
`default_nettype none

module node_ram #(
  parameter int WIDTH = 44,
  parameter int AW    = 3
) (
  input wire logic i_clk,
  node_ram_if.mem  mem
);

  logic [WIDTH-1:0] ram [2**AW];

  always_ff @(posedge i_clk) begin
    if (mem.we) begin
      ram[mem.addr] <= mem.wdata;
    end
    // Read every cycle, old contents on a collision with the write
    mem.rdata <= ram[mem.addr];
  end

  // The controller must never write through an unknown address
  a_wr_addr_known: assert property (
    @(posedge i_clk) mem.we |-> !$isunknown(mem.addr)
  );

endmodule

`default_nettype wire

// File: source/hash_crc.sv
// Bucket hash
// Combinational CRC-32 of the key, MSB first, zero initial value,
// reduced to the low bits that index the bucket memory
`timescale 1ns/1ns
`default_nettype none

module hash_crc #(
  parameter int KEY_BITS = 32,
  parameter int BKT_AW   = 3
) (
  input  wire logic [KEY_BITS-1:0] i_key,
  output logic      [BKT_AW-1:0]   o_idx
);

  logic [31:0] crc;
  logic        fb;

  // One polynomial division step per key bit
  always_comb begin
    crc = '0;
    fb  = 1'b0;
    for (int i = KEY_BITS - 1; i >= 0; i--) begin
      fb  = crc[31] ^ i_key[i];
      crc = {crc[30:0], 1'b0};
      if (fb) begin
        crc = crc ^ hash_map_pkg::CRC_POLY;
      end
    end
  end

  // No reflection and no final xor
  assign o_idx = crc[BKT_AW-1:0];

endmodule

`default_nettype wire

// File: source/node_ram_if.sv
// Node memory port
// One single-port memory access: address, write enable, write and read data
`timescale 1ns/1ns
`default_nettype none

interface node_ram_if #(
  parameter int WIDTH = 44,
  parameter int AW    = 3
);

  logic [AW-1:0]    addr;
  logic             we;
  logic [WIDTH-1:0] wdata;
  // Registered read data, shows the node addressed one cycle earlier
  logic [WIDTH-1:0] rdata;

  // Side of the control FSM
  modport ctrl (
    output addr,
    output we,
    output wdata,
    input  rdata
  );

  // Side of the memory
  modport mem (
    input  addr,
    input  we,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

// File: source/hash_map_pkg.sv
// Hash map shared definitions
// Opcodes, control states and the CRC-32 polynomial used for bucket hashing
`default_nettype none

package hash_map_pkg;

  // Request opcodes as seen on i_opcode
  typedef enum logic [0:0] {
    OP_LOOKUP = 1'b0,
    OP_ADD    = 1'b1
  } opcode_t;

  // Control FSM states
  typedef enum logic [2:0] {
    ST_CLEAR,
    ST_IDLE,
    ST_BKT_WAIT,
    ST_BKT_EVAL,
    ST_CHN_WAIT,
    ST_CHN_EVAL
  } state_t;

  // CRC-32 polynomial, normal form
  localparam logic [31:0] CRC_POLY = 32'h04C11DB7;

endpackage

`default_nettype wire
